// ==== logic/ringCtrlPkg.sv ====
/*
 Shared ring controller types and widths.
 Entry state values carry an st prefix so they do not collide with opcode names.
*/
package ringCtrlPkg;

    //========================================
    // Widths
    //========================================
    localparam int ADDR_W    = 32;
    localparam int DATA_W    = 32;
    localparam int CORE_ID_W = 8;  // Top address bits name the target core
    localparam int THREAD_W  = 2;

    //========================================
    // Ring command
    //========================================
    typedef enum logic [1:0] {
        rd      = 2'b00,
        rdRsp   = 2'b01, // Never accepted from the core side
        wr      = 2'b10,
        wrBcast = 2'b11  // Travels the whole ring and comes back
    } ringOpcodeT;

    // Request buffer entry life cycle
    typedef enum logic [2:0] {
        stFree         = 3'b000,
        stWrite        = 3'b001,
        stRead         = 3'b010,
        stReadPrgrs    = 3'b011, // Read on the ring, waiting for response
        stReadRdy      = 3'b100, // Data held, waiting for core return
        stWrBcast      = 3'b101,
        stWrBcastPrgrs = 3'b110  // Waiting for the broadcast to come home
    } entryStateT;

    // Address word, compared whole or split for routing
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        struct packed {
            logic [CORE_ID_W-1:0]        coreId;
            logic [ADDR_W-CORE_ID_W-1:0] offset;
        } fields;
    } ringAddrT;

endpackage

// ==== logic/ringMsgIf.sv ====
/*
 One ring message between internal stages, no handshake.
 The src side drives every field each cycle.
*/
`timescale 1ns/1ps

interface ringMsgIf;
    import ringCtrlPkg::*;

    logic              valid;
    ringOpcodeT        opcode;
    ringAddrT          addr;   // Raw and field views
    logic [DATA_W-1:0] data;

    // Producer side
    modport src (
        output valid, opcode, addr, data
    );

    // Consumer side
    modport snk (
        input valid, opcode, addr, data
    );

endinterface

// ==== logic/ringInputStage.sv ====
/*
 Ring input sample stage, one cycle of latency.
 Only the valid bit is reset, payload follows the ring freely.
*/
`timescale 1ns/1ps

module ringInputStage (
    input  logic                          QClk,
    input  logic                          rst,
    input  logic                          ringInValid,
    input  logic [1:0]                    ringInOpcode,
    input  logic [ringCtrlPkg::ADDR_W-1:0] ringInAddr,
    input  logic [ringCtrlPkg::DATA_W-1:0] ringInData,
    ringMsgIf.src                         inMsg
);
    import ringCtrlPkg::*;

    // Valid bit, cleared on reset
    always_ff @(posedge QClk) begin
        if (rst) begin
            inMsg.valid <= 1'b0;
        end else begin
            inMsg.valid <= ringInValid;
        end
    end

    // Payload register
    always_ff @(posedge QClk) begin
        inMsg.opcode <= ringOpcodeT'(ringInOpcode); // Every 2-bit code is legal
        inMsg.addr   <= ringInAddr;
        inMsg.data   <= ringInData;
    end

endmodule

// ==== logic/requestBuffer.sv ====
/*
 Core request buffer, numEntries deep, lowest index wins everywhere.
 Requests for this core, rdRsp requests and requests under stall are dropped.
 Read response data returns one entry per cycle, registered.
*/
`timescale 1ns/1ps

module requestBuffer #(
    parameter int numEntries = 4
) (
    input  logic                             QClk,
    input  logic                             rst,
    input  logic [ringCtrlPkg::CORE_ID_W-1:0] coreId,
    input  logic                             coreReqValid,
    input  logic [1:0]                       coreReqOpcode,
    input  logic [ringCtrlPkg::THREAD_W-1:0]  coreReqThreadId,
    input  logic [ringCtrlPkg::ADDR_W-1:0]    coreReqAddr,
    input  logic [ringCtrlPkg::DATA_W-1:0]    coreReqData,
    ringMsgIf.snk                            inMsg,
    ringMsgIf.src                            injMsg,
    input  logic                             injectTaken,
    output logic                             consume,
    output logic                             coreRspValid,
    output logic [ringCtrlPkg::THREAD_W-1:0]  coreRspThreadId,
    output logic [ringCtrlPkg::DATA_W-1:0]    coreRspData,
    output logic                             coreStall
);
    import ringCtrlPkg::*;

    localparam int idxW = $clog2(numEntries);

    // Entry storage
    entryStateT          entryState  [numEntries];
    ringOpcodeT          entryOpcode [numEntries];
    logic [THREAD_W-1:0] entryThread [numEntries];
    ringAddrT            entryAddr   [numEntries];
    logic [DATA_W-1:0]   entryData   [numEntries];

    logic [numEntries-1:0] freeVec;
    logic [numEntries-1:0] injVec;
    logic [numEntries-1:0] rdMatchVec;
    logic [numEntries-1:0] bcastMatchVec;
    logic [numEntries-1:0] rdyVec;
    logic [idxW-1:0]       allocIdx;
    logic [idxW-1:0]       injIdx;
    logic [idxW-1:0]       rdMatchIdx;
    logic [idxW-1:0]       bcastIdx;
    logic [idxW-1:0]       rdyIdx;
    ringAddrT              reqAddr;
    logic                  reqAccept;
    entryStateT            reqState;

    // Priority pick, lowest set bit
    function automatic logic [idxW-1:0] lowestSet(input logic [numEntries-1:0] vec);
        logic [idxW-1:0] idx;
        idx = '0;
        for (int i = numEntries - 1; i >= 0; i--) begin
            if (vec[i]) idx = idxW'(i);
        end
        return idx;
    endfunction

    //========================================
    // Entry scan
    //========================================
    always_comb begin
        for (int i = 0; i < numEntries; i++) begin
            freeVec[i] = (entryState[i] == stFree);
            injVec[i]  = (entryState[i] == stRead) || (entryState[i] == stWrite) ||
                         (entryState[i] == stWrBcast);
            rdyVec[i]  = (entryState[i] == stReadRdy);
            // Ring side matches use the whole address word
            rdMatchVec[i]    = inMsg.valid && (inMsg.opcode == rdRsp) &&
                               (entryState[i] == stReadPrgrs) &&
                               (inMsg.addr.raw == entryAddr[i].raw);
            bcastMatchVec[i] = inMsg.valid && (inMsg.opcode == wrBcast) &&
                               (entryState[i] == stWrBcastPrgrs) &&
                               (inMsg.addr.raw == entryAddr[i].raw);
        end
    end

    assign allocIdx   = lowestSet(freeVec);
    assign injIdx     = lowestSet(injVec);
    assign rdMatchIdx = lowestSet(rdMatchVec);
    assign bcastIdx   = lowestSet(bcastMatchVec);
    assign rdyIdx     = lowestSet(rdyVec);

    assign coreStall = ~|freeVec;                     // No room left
    assign consume   = (|rdMatchVec) | (|bcastMatchVec); // Ours, keep off the ring

    // Core request filter, routing by core id field
    assign reqAddr   = coreReqAddr;
    assign reqAccept = coreReqValid && !coreStall && (coreReqOpcode != rdRsp) &&
                       (reqAddr.fields.coreId != coreId);

    // Initial entry state from request opcode
    always_comb begin
        case (coreReqOpcode)
            rd:      reqState = stRead;
            wr:      reqState = stWrite;
            wrBcast: reqState = stWrBcast;
            default: reqState = stFree; // rdRsp, filtered above
        endcase
    end

    // Injection candidate toward the arbiter
    assign injMsg.valid  = |injVec;
    assign injMsg.opcode = entryOpcode[injIdx];
    assign injMsg.addr   = entryAddr[injIdx];
    assign injMsg.data   = entryData[injIdx];

    //========================================
    // Entry FSM and core response
    //========================================
    always_ff @(posedge QClk) begin
        if (rst) begin
            for (int i = 0; i < numEntries; i++) begin
                entryState[i] <= stFree;
            end
            coreRspValid <= 1'b0;
        end else begin
            for (int i = 0; i < numEntries; i++) begin
                case (entryState[i])
                    stFree:         if (reqAccept && allocIdx == i) entryState[i] <= reqState;
                    stWrite:        if (injectTaken && injIdx == i) entryState[i] <= stFree;
                    stRead:         if (injectTaken && injIdx == i) entryState[i] <= stReadPrgrs;
                    stWrBcast:      if (injectTaken && injIdx == i) entryState[i] <= stWrBcastPrgrs;
                    stReadPrgrs:    if (rdMatchVec[i] && rdMatchIdx == i) entryState[i] <= stReadRdy;
                    stReadRdy:      if (rdyIdx == i) entryState[i] <= stFree; // Returned below
                    stWrBcastPrgrs: if (bcastMatchVec[i] && bcastIdx == i) entryState[i] <= stFree;
                    default:        entryState[i] <= stFree;
                endcase
            end
            coreRspValid <= |rdyVec; // One ready entry per cycle
        end
    end

    // Payload fields
    always_ff @(posedge QClk) begin
        for (int i = 0; i < numEntries; i++) begin
            if (freeVec[i] && reqAccept && allocIdx == i) begin
                entryOpcode[i] <= ringOpcodeT'(coreReqOpcode);
                entryThread[i] <= coreReqThreadId;
                entryAddr[i]   <= reqAddr;
                entryData[i]   <= coreReqData;
            end else if (rdMatchVec[i] && rdMatchIdx == i) begin
                entryData[i] <= inMsg.data; // Response data replaces request data
            end
        end
        if (|rdyVec) begin
            coreRspThreadId <= entryThread[rdyIdx];
            coreRspData     <= entryData[rdyIdx];
        end
    end

endmodule

// ==== logic/ringOutputArbiter.sv ====
/*
 Ring output select, foreign traffic first, then injection, else idle.
 At most ventBurst injections back to back, then one slot without injection.
*/
`timescale 1ns/1ps

module ringOutputArbiter #(
    parameter int ventBurst = 3
) (
    input  logic                          QClk,
    input  logic                          rst,
    ringMsgIf.snk                         inMsg,
    ringMsgIf.snk                         injMsg,
    input  logic                          consume,
    output logic                          injectTaken,
    output logic                          ringOutValid,
    output logic [1:0]                    ringOutOpcode,
    output logic [ringCtrlPkg::ADDR_W-1:0] ringOutAddr,
    output logic [ringCtrlPkg::DATA_W-1:0] ringOutData
);
    import ringCtrlPkg::*;

    localparam int cntW = $clog2(ventBurst + 1);

    logic [cntW-1:0]   burstCnt;
    logic              forward;
    logic              nxtValid;
    logic [1:0]        nxtOpcode;
    logic [ADDR_W-1:0] nxtAddr;
    logic [DATA_W-1:0] nxtData;

    //========================================
    // Slot decision
    //========================================
    assign forward     = inMsg.valid && !consume;
    assign injectTaken = !forward && injMsg.valid && (burstCnt < ventBurst);

    always_comb begin
        if (forward) begin          // Pass foreign traffic unchanged
            nxtValid  = 1'b1;
            nxtOpcode = inMsg.opcode;
            nxtAddr   = inMsg.addr.raw;
            nxtData   = inMsg.data;
        end else if (injectTaken) begin
            nxtValid  = 1'b1;
            nxtOpcode = injMsg.opcode;
            nxtAddr   = injMsg.addr.raw;
            nxtData   = injMsg.data;
        end else begin              // Idle slot, all zero
            nxtValid  = 1'b0;
            nxtOpcode = '0;
            nxtAddr   = '0;
            nxtData   = '0;
        end
    end

    // Burst counter, clears on any slot without injection
    always_ff @(posedge QClk) begin
        if (rst) begin
            burstCnt <= '0;
        end else if (injectTaken) begin
            burstCnt <= burstCnt + 1'b1;
        end else begin
            burstCnt <= '0;
        end
    end

    //========================================
    // Ring output register
    //========================================
    always_ff @(posedge QClk) begin
        if (rst) begin
            ringOutValid <= 1'b0;
        end else begin
            ringOutValid <= nxtValid;
        end
    end

    always_ff @(posedge QClk) begin
        ringOutOpcode <= nxtOpcode;
        ringOutAddr   <= nxtAddr;
        ringOutData   <= nxtData;
    end

endmodule

// ==== logic/ringController.sv ====
/*
 Ring controller for one core, core-to-ring direction only.
 Foreign ring traffic takes 2 cycles in to out. The core sees pulses and a stall level.
*/
`timescale 1ns/1ps

module ringController #(
    parameter int numEntries = 4, // Power of two, 2 or more
    parameter int ventBurst  = 3
) (
    input  logic                             QClk,
    input  logic                             rst,
    input  logic [ringCtrlPkg::CORE_ID_W-1:0] coreId,
    // Ring in
    input  logic                             ringInValid,
    input  logic [1:0]                       ringInOpcode,
    input  logic [ringCtrlPkg::ADDR_W-1:0]    ringInAddr,
    input  logic [ringCtrlPkg::DATA_W-1:0]    ringInData,
    // Ring out
    output logic                             ringOutValid,
    output logic [1:0]                       ringOutOpcode,
    output logic [ringCtrlPkg::ADDR_W-1:0]    ringOutAddr,
    output logic [ringCtrlPkg::DATA_W-1:0]    ringOutData,
    // Core request
    input  logic                             coreReqValid,
    input  logic [1:0]                       coreReqOpcode,
    input  logic [ringCtrlPkg::THREAD_W-1:0]  coreReqThreadId,
    input  logic [ringCtrlPkg::ADDR_W-1:0]    coreReqAddr,
    input  logic [ringCtrlPkg::DATA_W-1:0]    coreReqData,
    // Core response
    output logic                             coreRspValid,
    output logic [ringCtrlPkg::THREAD_W-1:0]  coreRspThreadId,
    output logic [ringCtrlPkg::DATA_W-1:0]    coreRspData,
    output logic                             coreStall
);

    logic consume;     // Buffer claims current input message
    logic injectTaken; // Arbiter placed injMsg on the ring

    ringMsgIf inMsg ();
    ringMsgIf injMsg ();

    ringInputStage u_ringInputStage (
        .QClk         (QClk),
        .rst          (rst),
        .ringInValid  (ringInValid),
        .ringInOpcode (ringInOpcode),
        .ringInAddr   (ringInAddr),
        .ringInData   (ringInData),
        .inMsg        (inMsg.src)
    );

    requestBuffer #(.numEntries(numEntries)) u_requestBuffer (
        .QClk            (QClk),
        .rst             (rst),
        .coreId          (coreId),
        .coreReqValid    (coreReqValid),
        .coreReqOpcode   (coreReqOpcode),
        .coreReqThreadId (coreReqThreadId),
        .coreReqAddr     (coreReqAddr),
        .coreReqData     (coreReqData),
        .inMsg           (inMsg.snk),
        .injMsg          (injMsg.src),
        .injectTaken     (injectTaken),
        .consume         (consume),
        .coreRspValid    (coreRspValid),
        .coreRspThreadId (coreRspThreadId),
        .coreRspData     (coreRspData),
        .coreStall       (coreStall)
    );

    ringOutputArbiter #(.ventBurst(ventBurst)) u_ringOutputArbiter (
        .QClk          (QClk),
        .rst           (rst),
        .inMsg         (inMsg.snk),
        .injMsg        (injMsg.snk),
        .consume       (consume),
        .injectTaken   (injectTaken),
        .ringOutValid  (ringOutValid),
        .ringOutOpcode (ringOutOpcode),
        .ringOutAddr   (ringOutAddr),
        .ringOutData   (ringOutData)
    );

endmodule

// ==== test/ringControllerChecker.sv ====
/*
 Compares DUT outputs with the expected row once per cycle, at the falling edge.
 Payload fields are compared only where the row expects a valid event.
*/
`timescale 1ns/1ps

module ringControllerChecker (
    input  logic        QClk,
    input  logic        arm,            // Row expectations are live
    input  logic        done,           // Table finished, report last test
    input  logic [2:0]  testNum,
    input  logic        expOutValid,
    input  logic [1:0]  expOutOpcode,
    input  logic [31:0] expOutAddr,
    input  logic [31:0] expOutData,
    input  logic        expRspValid,
    input  logic [1:0]  expRspThreadId,
    input  logic [31:0] expRspData,
    input  logic        expStall,
    input  logic        ringOutValid,
    input  logic [1:0]  ringOutOpcode,
    input  logic [31:0] ringOutAddr,
    input  logic [31:0] ringOutData,
    input  logic        coreRspValid,
    input  logic [1:0]  coreRspThreadId,
    input  logic [31:0] coreRspData,
    input  logic        coreStall,
    output int          checkCount,
    output int          errCount
);

    logic [2:0] curTest;    // 0 until the first armed row
    int         testChecks;
    int         testErrors;
    logic       reported;

    initial begin
        checkCount = 0;
        errCount   = 0;
        curTest    = '0;
        testChecks = 0;
        testErrors = 0;
        reported   = 1'b0;
    end

    function automatic string testName(input logic [2:0] t);
        case (t)
            3'd1:    return "pass-through";
            3'd2:    return "write injection";
            3'd3:    return "read round trip";
            3'd4:    return "broadcast";
            3'd5:    return "full buffer";
            3'd6:    return "burst limit";
            default: return "unknown";
        endcase
    endfunction

    // One compare, one count
    task automatic compareField(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checkCount++;
        testChecks++;
        if (got !== exp) begin
            errCount++;
            testErrors++;
            $display("[ERROR] time %0d ns: %s expected %0h got %0h", $time, name, exp, got);
        end
    endtask

    task automatic reportTest();
        $display("Test %0d %s: %0d checks, %0d errors, %s", curTest, testName(curTest),
                 testChecks, testErrors, (testErrors == 0) ? "ok" : "FAIL");
        testChecks = 0;
        testErrors = 0;
    endtask

    //========================================
    // Per cycle compare
    //========================================
    always @(negedge QClk) begin
        if (arm) begin
            if (curTest != 3'd0 && curTest != testNum) reportTest(); // Test boundary
            curTest = testNum;
            compareField("ringOutValid", 32'(ringOutValid), 32'(expOutValid));
            if (expOutValid) begin
                compareField("ringOutOpcode", 32'(ringOutOpcode), 32'(expOutOpcode));
                compareField("ringOutAddr", ringOutAddr, expOutAddr);
                compareField("ringOutData", ringOutData, expOutData);
            end
            compareField("coreRspValid", 32'(coreRspValid), 32'(expRspValid));
            if (expRspValid) begin
                compareField("coreRspThreadId", 32'(coreRspThreadId), 32'(expRspThreadId));
                compareField("coreRspData", coreRspData, expRspData);
            end
            compareField("coreStall", 32'(coreStall), 32'(expStall));
        end else if (done && !reported && curTest != 3'd0) begin
            reportTest();
            reported = 1'b1;
        end
    end

endmodule

// ==== test/ringControllerTb.sv ====
/*
 Table driven testbench, core id 8'h05, numEntries 4, ventBurst 3.
 Each row is applied 1 ns after a rising edge and holds the outputs expected in that cycle.
 Ring input shows at the ring output 2 rows later.
*/
`timescale 1ns/1ps

module ringControllerTb;
    import ringCtrlPkg::*;

    localparam int         clkPeriod = 100;
    localparam int         numSteps  = 59;
    localparam logic [7:0] ownCore   = 8'h05;

    // One table row, stimulus and expected outputs of the same cycle
    typedef struct packed {
        logic [2:0]  test;
        logic        inValid;
        logic [1:0]  inOpcode;
        logic [31:0] inAddr;
        logic [31:0] inData;
        logic        reqValid;
        logic [1:0]  reqOpcode;
        logic [1:0]  reqThread;
        logic [31:0] reqAddr;
        logic [31:0] reqData;
        logic        outValid;
        logic [1:0]  outOpcode;
        logic [31:0] outAddr;
        logic [31:0] outData;
        logic        rspValid;
        logic [1:0]  rspThread;
        logic [31:0] rspData;
        logic        stall;
    } stepT;

    stepT        steps [numSteps];
    stepT        cur;              // Row being applied
    logic [31:0] rnd [24];         // Random data words
    integer      seed;

    logic        QClk;
    logic        rst;
    logic        arm;
    logic        done;
    logic        ringOutValid;
    logic [1:0]  ringOutOpcode;
    logic [31:0] ringOutAddr;
    logic [31:0] ringOutData;
    logic        coreRspValid;
    logic [1:0]  coreRspThreadId;
    logic [31:0] coreRspData;
    logic        coreStall;
    int          checkCount;
    int          errCount;

    initial QClk = 1'b0;
    always #(clkPeriod / 2) QClk = ~QClk;

    //========================================
    // Table helpers
    //========================================
    task automatic ringIn(input int s, input logic [1:0] op, input logic [31:0] addr,
                          input logic [31:0] data);
        steps[s].inValid  = 1'b1;
        steps[s].inOpcode = op;
        steps[s].inAddr   = addr;
        steps[s].inData   = data;
    endtask

    task automatic expectOut(input int s, input logic [1:0] op, input logic [31:0] addr,
                             input logic [31:0] data);
        steps[s].outValid  = 1'b1;
        steps[s].outOpcode = op;
        steps[s].outAddr   = addr;
        steps[s].outData   = data;
    endtask

    // Foreign traffic, unchanged two cycles later
    task automatic passThrough(input int s, input logic [1:0] op, input logic [31:0] addr,
                               input logic [31:0] data);
        ringIn(s, op, addr, data);
        expectOut(s + 2, op, addr, data);
    endtask

    task automatic coreReq(input int s, input logic [1:0] op, input logic [1:0] tid,
                           input logic [31:0] addr, input logic [31:0] data);
        steps[s].reqValid  = 1'b1;
        steps[s].reqOpcode = op;
        steps[s].reqThread = tid;
        steps[s].reqAddr   = addr;
        steps[s].reqData   = data;
    endtask

    task automatic expectRsp(input int s, input logic [1:0] tid, input logic [31:0] data);
        steps[s].rspValid  = 1'b1;
        steps[s].rspThread = tid;
        steps[s].rspData   = data;
    endtask

    task automatic buildTable();
        int firstRow [6];
        firstRow = '{0, 7, 16, 24, 32, 49};
        for (int s = 0; s < numSteps; s++) steps[s] = '0;
        for (int t = 0; t < 6; t++) begin
            for (int s = firstRow[t]; s < numSteps; s++) steps[s].test = 3'(t + 1);
        end
        // Pass-through of every opcode
        passThrough(0, wr, 32'h1200_0010, rnd[0]);
        passThrough(1, rd, 32'h3400_0020, rnd[1]);
        passThrough(3, rdRsp, 32'h5600_0030, rnd[2]);   // No read pending
        passThrough(4, wrBcast, 32'h7800_0040, rnd[3]);
        // Write injection, idle ring then busy ring
        coreReq(7, wr, 2'd1, 32'h2100_0100, rnd[4]);
        expectOut(9, wr, 32'h2100_0100, rnd[4]);
        coreReq(10, wr, 2'd2, 32'h2200_0300, rnd[5]);
        passThrough(10, wr, 32'h1200_0200, rnd[6]);
        passThrough(11, rd, 32'h1300_0210, rnd[7]);
        expectOut(14, wr, 32'h2200_0300, rnd[5]);       // First idle slot
        // Read round trip
        coreReq(16, rd, 2'd2, 32'h3100_0400, 32'h0);
        expectOut(18, rd, 32'h3100_0400, 32'h0);
        ringIn(19, rdRsp, 32'h3100_0400, rnd[8]);       // Consumed
        passThrough(20, rdRsp, 32'h3100_0404, rnd[9]);  // Other address
        expectRsp(22, 2'd2, rnd[8]);
        // Broadcast goes round and is removed
        coreReq(24, wrBcast, 2'd0, 32'h4100_0500, rnd[10]);
        expectOut(26, wrBcast, 32'h4100_0500, rnd[10]);
        ringIn(27, wrBcast, 32'h4100_0500, rnd[10]);
        passThrough(29, wrBcast, 32'h4100_0500, rnd[11]); // Entry already free
        // Full buffer, burst gap after third read
        for (int i = 0; i < 4; i++) begin
            coreReq(32 + i, rd, 2'(i), 32'h5100_0600 + 32'(4 * i), 32'h0);
            expectOut((i == 3) ? 38 : 34 + i, rd, 32'h5100_0600 + 32'(4 * i), 32'h0);
        end
        for (int s = 36; s <= 40; s++) steps[s].stall = 1'b1;
        coreReq(36, wr, 2'd0, 32'h5200_0700, rnd[12]);  // Dropped under stall
        ringIn(38, rdRsp, 32'h5100_0600, rnd[13]);
        expectRsp(41, 2'd0, rnd[13]);
        coreReq(41, wr, 2'd1, {ownCore, 24'h00_0900}, rnd[14]); // Own core id
        coreReq(42, rdRsp, 2'd1, 32'h5300_0000, rnd[15]);
        for (int i = 1; i < 4; i++) begin
            ringIn(42 + i, rdRsp, 32'h5100_0600 + 32'(4 * i), rnd[15 + i]);
            expectRsp(45 + i, 2'(i), rnd[15 + i]);
        end
        // Burst limit, lowest index entry goes first after the gap
        for (int i = 0; i < 5; i++) begin
            coreReq(49 + i, wr, 2'(i % 4), 32'h6100_0A00 + 32'(4 * i), rnd[19 + i]);
        end
        for (int i = 0; i < 3; i++) begin
            expectOut(51 + i, wr, 32'h6100_0A00 + 32'(4 * i), rnd[19 + i]);
        end
        expectOut(55, wr, 32'h6100_0A10, rnd[23]);
        expectOut(56, wr, 32'h6100_0A0C, rnd[22]);
    endtask

    //========================================
    // DUT and checker
    //========================================
    ringController #(.numEntries(4), .ventBurst(3)) u_ringController (
        .QClk            (QClk),
        .rst             (rst),
        .coreId          (ownCore),
        .ringInValid     (cur.inValid),
        .ringInOpcode    (cur.inOpcode),
        .ringInAddr      (cur.inAddr),
        .ringInData      (cur.inData),
        .ringOutValid    (ringOutValid),
        .ringOutOpcode   (ringOutOpcode),
        .ringOutAddr     (ringOutAddr),
        .ringOutData     (ringOutData),
        .coreReqValid    (cur.reqValid),
        .coreReqOpcode   (cur.reqOpcode),
        .coreReqThreadId (cur.reqThread),
        .coreReqAddr     (cur.reqAddr),
        .coreReqData     (cur.reqData),
        .coreRspValid    (coreRspValid),
        .coreRspThreadId (coreRspThreadId),
        .coreRspData     (coreRspData),
        .coreStall       (coreStall)
    );

    ringControllerChecker u_ringControllerChecker (
        .QClk            (QClk),
        .arm             (arm),
        .done            (done),
        .testNum         (cur.test),
        .expOutValid     (cur.outValid),
        .expOutOpcode    (cur.outOpcode),
        .expOutAddr      (cur.outAddr),
        .expOutData      (cur.outData),
        .expRspValid     (cur.rspValid),
        .expRspThreadId  (cur.rspThread),
        .expRspData      (cur.rspData),
        .expStall        (cur.stall),
        .ringOutValid    (ringOutValid),
        .ringOutOpcode   (ringOutOpcode),
        .ringOutAddr     (ringOutAddr),
        .ringOutData     (ringOutData),
        .coreRspValid    (coreRspValid),
        .coreRspThreadId (coreRspThreadId),
        .coreRspData     (coreRspData),
        .coreStall       (coreStall),
        .checkCount      (checkCount),
        .errCount        (errCount)
    );

    //========================================
    // Stimulus loop
    //========================================
    initial begin
        seed = 54;
        cur  = '0;
        arm  = 1'b0;
        done = 1'b0;
        rst  = 1'b1;
        for (int i = 0; i < 24; i++) rnd[i] = $random(seed);
        buildTable();
        repeat (2) @(posedge QClk);
        #1 rst = 1'b0;
        for (int s = 0; s < numSteps; s++) begin
            @(posedge QClk);
            #1;
            cur = steps[s];
            arm = 1'b1;
        end
        @(posedge QClk);
        #1;
        cur  = '0;
        arm  = 1'b0;
        done = 1'b1;
        @(negedge QClk);
        #1;    // Let the checker report the last test
        $display("Checks: %0d, errors: %0d", checkCount, errCount);
        if (errCount == 0 && checkCount > 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Watchdog, table length plus margin
    initial begin
        #((numSteps + 20) * clkPeriod);
        $display("Timeout: the stimulus table did not finish in time");
        $display("Testbench failed");
        $finish;
    end

endmodule

// ==== ringController.f ====
logic/ringCtrlPkg.sv
logic/ringMsgIf.sv
logic/ringInputStage.sv
logic/requestBuffer.sv
logic/ringOutputArbiter.sv
logic/ringController.sv
test/ringControllerChecker.sv
test/ringControllerTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Verilator build and run of the ring controller testbench
# Pass is decided by the pass line in the simulation output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module ringControllerTb \
    -f ringController.f -o ringSim || { echo "Verilator build failed"; exit 1; }

./obj_dir/ringSim | tee /dev/stderr | grep "Testbench passed" > /dev/null \
    && { echo "Run status: pass"; exit 0; } \
    || { echo "Run status: fail"; exit 1; }
